//--- source/soc_pkg.sv
// ------------------------------------------------------------
// Bus widths, op codes, device map and counter sizes of the SoC.
// Referenced by scoped name from the RTL and the testbench.
// ------------------------------------------------------------
`default_nettype none

package soc_pkg;

	// ------------------------------------------------------------
	// PI1 bus.
	localparam int ARCHBITSZ = 32;
	localparam int SELBITSZ = ARCHBITSZ / 8;
	localparam int ADDRBITSZ = ARCHBITSZ - $clog2(SELBITSZ); // Word address.

	localparam logic [1:0] PI1_OP_IDLE = 2'd0;
	localparam logic [1:0] PI1_OP_WRITE = 2'd1;
	localparam logic [1:0] PI1_OP_READ = 2'd2;

	// ------------------------------------------------------------
	// Device map.
	localparam int DEV_COUNT = 3;
	localparam int DEV_IDX_BITSZ = $clog2(DEV_COUNT);

	localparam logic [DEV_IDX_BITSZ-1:0] DEV_IDX_DEVTBL = 2'd0;
	localparam logic [DEV_IDX_BITSZ-1:0] DEV_IDX_GPIO = 2'd1;
	localparam logic [DEV_IDX_BITSZ-1:0] DEV_IDX_INVALID = 2'd2;

	localparam logic [ARCHBITSZ-1:0] DEVTBL_ID = 32'd7;
	localparam logic [ARCHBITSZ-1:0] GPIO_ID = 32'd6;
	localparam logic [ARCHBITSZ-1:0] INVALID_ID = 32'd0;

	// Sizes in words.
	localparam logic [ADDRBITSZ-1:0] DEVTBL_MAPSZ = 30'd16;
	localparam logic [ADDRBITSZ-1:0] GPIO_MAPSZ = 30'd4;
	localparam logic [ADDRBITSZ-1:0] INVALID_MAPSZ = 30'd1024;

	localparam logic [ADDRBITSZ-1:0] DEVTBL_BASE = 30'd0;
	localparam logic [ADDRBITSZ-1:0] GPIO_BASE = DEVTBL_BASE + DEVTBL_MAPSZ;

	localparam int DEVTBL_ADDRBITSZ = $clog2(DEVTBL_MAPSZ);
	localparam int GPIO_ADDRBITSZ = $clog2(GPIO_MAPSZ);

	localparam logic [DEV_COUNT-1:0] USEINTR_FLAGS = 3'b010; // Indexed by table entry.
	localparam logic [DEVTBL_ADDRBITSZ-1:0] DEVTBL_CTRL_WORD = 4'd15;

	localparam int GPIO_COUNT = 8;

	// ------------------------------------------------------------
	// Counters.
	localparam int RST_CNTR_BITSZ = 8;
	localparam logic [RST_CNTR_BITSZ-1:0] RST_CYCLES = '1;
	localparam int ACTIVITY_CNTR_BITSZ = 7;
	localparam logic [ACTIVITY_CNTR_BITSZ-1:0] ACTIVITY_HOLDOFF = '1;

endpackage

`default_nettype wire

//--- source/rst_sequencer.sv
// ------------------------------------------------------------
// Peripheral reset sequencer with software warm, cold and power-off.
// ------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module rst_sequencer (
	input  logic clk100mhz,
	input  logic rst_p,
	input  logic sw_rst0_i,
	input  logic sw_rst1_i,
	output logic periph_rst_o
);

	logic [soc_pkg::RST_CNTR_BITSZ-1:0] rst_cntr;
	logic pwroff_q;
	logic sw_warm;
	logic sw_cold;
	logic sw_pwroff;

	// Request decode from the two control bits.
	assign sw_warm = !sw_rst0_i && sw_rst1_i;
	assign sw_cold = sw_rst0_i && sw_rst1_i; // Same effect as warm here.
	assign sw_pwroff = sw_rst0_i && !sw_rst1_i;

	// ------------------------------------------------------------
	// Hold-off counter.
	always_ff @(posedge clk100mhz) begin
		if (rst_p || sw_warm || sw_cold) begin
			rst_cntr <= soc_pkg::RST_CYCLES;
		end else if (rst_cntr != '0) begin
			rst_cntr <= rst_cntr - 1'b1;
		end
	end

	// Power-off stays latched until the board reset.
	always_ff @(posedge clk100mhz) begin
		if (rst_p) begin
			pwroff_q <= 1'b0;
		end else if (sw_pwroff) begin
			pwroff_q <= 1'b1;
		end
	end

	assign periph_rst_o = (rst_cntr != '0) || pwroff_q;

endmodule

`default_nettype wire

//--- source/devtbl_regs.sv
// ------------------------------------------------------------
// Read-only device table on PI1, plus the software reset control word.
// Entry k is at words 2k (id) and 2k+1 (useintr flag and map size).
// ------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module devtbl_regs (
	input  logic                                  clk100mhz,
	input  logic                                  rst_p,
	input  logic [1:0]                            op_i,
	input  logic [soc_pkg::DEVTBL_ADDRBITSZ-1:0]  addr_i,
	input  logic [soc_pkg::ARCHBITSZ-1:0]         data_i,
	input  logic [soc_pkg::SELBITSZ-1:0]          sel_i,
	output logic [soc_pkg::ARCHBITSZ-1:0]         data_o,
	output logic                                  rdy_o,
	output logic                                  sw_rst0_o,
	output logic                                  sw_rst1_o
);

	logic [soc_pkg::ARCHBITSZ-1:0] dev_id [soc_pkg::DEV_COUNT];
	logic [soc_pkg::ARCHBITSZ-2:0] dev_mapsz [soc_pkg::DEV_COUNT];
	logic [soc_pkg::ARCHBITSZ-1:0] rd_word;
	logic req;
	logic wr_ctrl;

	// ------------------------------------------------------------
	// Table contents.
	assign dev_id[soc_pkg::DEV_IDX_DEVTBL] = soc_pkg::DEVTBL_ID;
	assign dev_id[soc_pkg::DEV_IDX_GPIO] = soc_pkg::GPIO_ID;
	assign dev_id[soc_pkg::DEV_IDX_INVALID] = soc_pkg::INVALID_ID;

	assign dev_mapsz[soc_pkg::DEV_IDX_DEVTBL] = {1'b0, soc_pkg::DEVTBL_MAPSZ};
	assign dev_mapsz[soc_pkg::DEV_IDX_GPIO] = {1'b0, soc_pkg::GPIO_MAPSZ};
	assign dev_mapsz[soc_pkg::DEV_IDX_INVALID] = {1'b0, soc_pkg::INVALID_MAPSZ};

	always_comb begin
		rd_word = '0;
		for (int k = 0; k < soc_pkg::DEV_COUNT; k++) begin
			if (addr_i[soc_pkg::DEVTBL_ADDRBITSZ-1:1] == (soc_pkg::DEVTBL_ADDRBITSZ-1)'(k)) begin
				rd_word = addr_i[0] ? {soc_pkg::USEINTR_FLAGS[k], dev_mapsz[k]} : dev_id[k];
			end
		end
		if (addr_i == soc_pkg::DEVTBL_CTRL_WORD) begin
			rd_word = {{(soc_pkg::ARCHBITSZ-2){1'b0}}, sw_rst1_o, sw_rst0_o};
		end
	end

	// ------------------------------------------------------------
	// PI1 slave side.
	assign req = (op_i != soc_pkg::PI1_OP_IDLE);

	always_ff @(posedge clk100mhz) begin
		if (rst_p) begin
			rdy_o <= 1'b0;
		end else begin
			rdy_o <= req && !rdy_o; // One cycle after the request.
		end
	end

	always_ff @(posedge clk100mhz) begin
		if (req && !rdy_o) begin
			data_o <= rd_word;
		end
	end

	// Control word lands at the completing edge.
	assign wr_ctrl = (op_i == soc_pkg::PI1_OP_WRITE) && rdy_o &&
		(addr_i == soc_pkg::DEVTBL_CTRL_WORD) && sel_i[0];

	always_ff @(posedge clk100mhz) begin
		if (rst_p) begin
			sw_rst0_o <= 1'b0;
			sw_rst1_o <= 1'b0;
		end else if (wr_ctrl) begin
			sw_rst0_o <= data_i[0];
			sw_rst1_o <= data_i[1];
		end
	end

endmodule

`default_nettype wire

//--- source/gpio_port.sv
// ------------------------------------------------------------
// GPIO on PI1. Word 0 reads the synchronised inputs, word 1 the outputs.
// ------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module gpio_port (
	input  logic                                clk100mhz,
	input  logic                                rst_p,
	input  logic [1:0]                          op_i,
	input  logic [soc_pkg::GPIO_ADDRBITSZ-1:0]  addr_i,
	input  logic [soc_pkg::ARCHBITSZ-1:0]       data_i,
	input  logic [soc_pkg::SELBITSZ-1:0]        sel_i,
	input  logic [soc_pkg::GPIO_COUNT-1:0]      gp_i,
	output logic [soc_pkg::ARCHBITSZ-1:0]       data_o,
	output logic                                rdy_o,
	output logic [soc_pkg::GPIO_COUNT-1:0]      gp_o
);

	logic [soc_pkg::GPIO_COUNT-1:0] gp_meta;
	logic [soc_pkg::GPIO_COUNT-1:0] gp_sync;
	logic [soc_pkg::ARCHBITSZ-1:0] rd_word;
	logic req;
	logic wr_out;

	// Two-flop input synchroniser.
	always_ff @(posedge clk100mhz) begin
		gp_meta <= gp_i;
		gp_sync <= gp_meta;
	end

	always_comb begin
		case (addr_i)
			2'd0: rd_word = {{(soc_pkg::ARCHBITSZ-soc_pkg::GPIO_COUNT){1'b0}}, gp_sync};
			2'd1: rd_word = {{(soc_pkg::ARCHBITSZ-soc_pkg::GPIO_COUNT){1'b0}}, gp_o};
			default: rd_word = '0;
		endcase
	end

	// ------------------------------------------------------------
	// PI1 slave side.
	assign req = (op_i != soc_pkg::PI1_OP_IDLE);
	assign wr_out = (op_i == soc_pkg::PI1_OP_WRITE) && rdy_o && (addr_i == 2'd1) && sel_i[0];

	always_ff @(posedge clk100mhz) begin
		if (rst_p) begin
			rdy_o <= 1'b0;
		end else begin
			rdy_o <= req && !rdy_o;
		end
	end

	always_ff @(posedge clk100mhz) begin
		if (req && !rdy_o) begin
			data_o <= rd_word; // Valid in the ready cycle.
		end
	end

	always_ff @(posedge clk100mhz) begin
		if (rst_p) begin
			gp_o <= '0;
		end else if (wr_out) begin
			gp_o <= data_i[soc_pkg::GPIO_COUNT-1:0];
		end
	end

endmodule

`default_nettype wire

//--- source/pi1_router.sv
// ------------------------------------------------------------
// PI1 address router for one master, with invalid-device responder
// and the bus activity blinker.
// ------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module pi1_router (
	input  logic                                  clk100mhz,
	input  logic                                  rst_p,
	input  logic [1:0]                            m_op_i,
	input  logic [soc_pkg::ADDRBITSZ-1:0]         m_addr_i,
	input  logic [soc_pkg::ARCHBITSZ-1:0]         m_data_i,
	input  logic [soc_pkg::SELBITSZ-1:0]          m_sel_i,
	input  logic [soc_pkg::ARCHBITSZ-1:0]         devtbl_data_i,
	input  logic                                  devtbl_rdy_i,
	input  logic [soc_pkg::ARCHBITSZ-1:0]         gpio_data_i,
	input  logic                                  gpio_rdy_i,
	output logic [soc_pkg::ARCHBITSZ-1:0]         m_data_o,
	output logic                                  m_rdy_o,
	output logic [1:0]                            devtbl_op_o,
	output logic [soc_pkg::DEVTBL_ADDRBITSZ-1:0]  devtbl_addr_o,
	output logic [soc_pkg::ARCHBITSZ-1:0]         devtbl_data_o,
	output logic [soc_pkg::SELBITSZ-1:0]          devtbl_sel_o,
	output logic [1:0]                            gpio_op_o,
	output logic [soc_pkg::GPIO_ADDRBITSZ-1:0]    gpio_addr_o,
	output logic [soc_pkg::ARCHBITSZ-1:0]         gpio_data_o,
	output logic [soc_pkg::SELBITSZ-1:0]          gpio_sel_o,
	output logic                                  activity_o
);

	logic [soc_pkg::ADDRBITSZ-1:0] devtbl_off;
	logic [soc_pkg::ADDRBITSZ-1:0] gpio_off;
	logic [soc_pkg::DEV_IDX_BITSZ-1:0] dec_idx;
	logic [soc_pkg::DEV_IDX_BITSZ-1:0] idx_q;
	logic [soc_pkg::DEV_IDX_BITSZ-1:0] cur_idx;
	logic busy_q;
	logic req;
	logic [1:0] fwd_op;
	logic inv_rdy_q;
	logic [soc_pkg::ACTIVITY_CNTR_BITSZ-1:0] act_cntr;

	// ------------------------------------------------------------
	// Address decode.
	assign devtbl_off = m_addr_i - soc_pkg::DEVTBL_BASE;
	assign gpio_off = m_addr_i - soc_pkg::GPIO_BASE;

	always_comb begin
		if (devtbl_off < soc_pkg::DEVTBL_MAPSZ) begin
			dec_idx = soc_pkg::DEV_IDX_DEVTBL;
		end else if (gpio_off < soc_pkg::GPIO_MAPSZ) begin
			dec_idx = soc_pkg::DEV_IDX_GPIO;
		end else begin
			dec_idx = soc_pkg::DEV_IDX_INVALID; // Everything else.
		end
	end

	assign req = (m_op_i != soc_pkg::PI1_OP_IDLE);
	assign cur_idx = busy_q ? idx_q : dec_idx;

	// Swap (op 3) goes out as a plain read.
	always_comb begin
		if (!req) begin
			fwd_op = soc_pkg::PI1_OP_IDLE;
		end else if (m_op_i == soc_pkg::PI1_OP_WRITE) begin
			fwd_op = soc_pkg::PI1_OP_WRITE;
		end else begin
			fwd_op = soc_pkg::PI1_OP_READ;
		end
	end

	assign devtbl_op_o = (cur_idx == soc_pkg::DEV_IDX_DEVTBL) ? fwd_op : soc_pkg::PI1_OP_IDLE;
	assign devtbl_addr_o = devtbl_off[soc_pkg::DEVTBL_ADDRBITSZ-1:0];
	assign devtbl_data_o = m_data_i;
	assign devtbl_sel_o = m_sel_i;

	assign gpio_op_o = (cur_idx == soc_pkg::DEV_IDX_GPIO) ? fwd_op : soc_pkg::PI1_OP_IDLE;
	assign gpio_addr_o = gpio_off[soc_pkg::GPIO_ADDRBITSZ-1:0];
	assign gpio_data_o = m_data_i;
	assign gpio_sel_o = m_sel_i;

	// ------------------------------------------------------------
	// Open access tracking and invalid responder.
	always_ff @(posedge clk100mhz) begin
		if (rst_p) begin
			busy_q <= 1'b0;
			idx_q <= soc_pkg::DEV_IDX_INVALID;
		end else begin
			if (m_rdy_o) begin
				busy_q <= 1'b0; // Completes at this edge.
			end else if (req) begin
				busy_q <= 1'b1;
			end
			if (!busy_q) begin
				idx_q <= dec_idx;
			end
		end
	end

	always_ff @(posedge clk100mhz) begin
		if (rst_p) begin
			inv_rdy_q <= 1'b0;
		end else begin
			inv_rdy_q <= (cur_idx == soc_pkg::DEV_IDX_INVALID) && req && !inv_rdy_q;
		end
	end

	always_comb begin
		case (cur_idx)
			soc_pkg::DEV_IDX_DEVTBL: begin
				m_data_o = devtbl_data_i;
				m_rdy_o = devtbl_rdy_i;
			end
			soc_pkg::DEV_IDX_GPIO: begin
				m_data_o = gpio_data_i;
				m_rdy_o = gpio_rdy_i;
			end
			default: begin
				m_data_o = '0;
				m_rdy_o = inv_rdy_q;
			end
		endcase
	end

	// ------------------------------------------------------------
	// Activity blinker.
	always_ff @(posedge clk100mhz) begin
		if (rst_p) begin
			act_cntr <= '0;
			activity_o <= 1'b0;
		end else if (act_cntr != '0) begin
			activity_o <= 1'b0;
			act_cntr <= act_cntr - 1'b1;
		end else if (m_rdy_o) begin
			activity_o <= 1'b1;
			act_cntr <= soc_pkg::ACTIVITY_HOLDOFF;
		end else begin
			activity_o <= 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- source/soc_top.sv
// ------------------------------------------------------------
// SoC bus fabric top. External PI1 master port, device table, GPIO
// and the peripheral reset sequencer.
// ------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module soc_top (
	input  logic                              clk100mhz,
	input  logic                              rst_p,
	input  logic [1:0]                        m_op_i,
	input  logic [soc_pkg::ADDRBITSZ-1:0]     m_addr_i,
	input  logic [soc_pkg::ARCHBITSZ-1:0]     m_data_i,
	input  logic [soc_pkg::SELBITSZ-1:0]      m_sel_i,
	input  logic [soc_pkg::GPIO_COUNT-1:0]    gp_i,
	output logic [soc_pkg::ARCHBITSZ-1:0]     m_data_o,
	output logic                              m_rdy_o,
	output logic [soc_pkg::GPIO_COUNT-1:0]    gp_o,
	output logic                              periph_rst_o,
	output logic                              activity_o
);

	logic periph_rst;
	logic sw_rst0;
	logic sw_rst1;

	// ------------------------------------------------------------
	// Router to slave nets.
	logic [1:0] devtbl_op;
	logic [soc_pkg::DEVTBL_ADDRBITSZ-1:0] devtbl_addr;
	logic [soc_pkg::ARCHBITSZ-1:0] devtbl_wdata;
	logic [soc_pkg::ARCHBITSZ-1:0] devtbl_rdata;
	logic [soc_pkg::SELBITSZ-1:0] devtbl_sel;
	logic devtbl_rdy;

	logic [1:0] gpio_op;
	logic [soc_pkg::GPIO_ADDRBITSZ-1:0] gpio_addr;
	logic [soc_pkg::ARCHBITSZ-1:0] gpio_wdata;
	logic [soc_pkg::ARCHBITSZ-1:0] gpio_rdata;
	logic [soc_pkg::SELBITSZ-1:0] gpio_sel;
	logic gpio_rdy;

	pi1_router pi1_router_inst (
		.clk100mhz     (clk100mhz),
		.rst_p         (periph_rst),
		.m_op_i        (m_op_i),
		.m_addr_i      (m_addr_i),
		.m_data_i      (m_data_i),
		.m_sel_i       (m_sel_i),
		.devtbl_data_i (devtbl_rdata),
		.devtbl_rdy_i  (devtbl_rdy),
		.gpio_data_i   (gpio_rdata),
		.gpio_rdy_i    (gpio_rdy),
		.m_data_o      (m_data_o),
		.m_rdy_o       (m_rdy_o),
		.devtbl_op_o   (devtbl_op),
		.devtbl_addr_o (devtbl_addr),
		.devtbl_data_o (devtbl_wdata),
		.devtbl_sel_o  (devtbl_sel),
		.gpio_op_o     (gpio_op),
		.gpio_addr_o   (gpio_addr),
		.gpio_data_o   (gpio_wdata),
		.gpio_sel_o    (gpio_sel),
		.activity_o    (activity_o)
	);

	devtbl_regs devtbl_regs_inst (
		.clk100mhz (clk100mhz),
		.rst_p     (periph_rst),
		.op_i      (devtbl_op),
		.addr_i    (devtbl_addr),
		.data_i    (devtbl_wdata),
		.sel_i     (devtbl_sel),
		.data_o    (devtbl_rdata),
		.rdy_o     (devtbl_rdy),
		.sw_rst0_o (sw_rst0),
		.sw_rst1_o (sw_rst1)
	);

	gpio_port gpio_port_inst (
		.clk100mhz (clk100mhz),
		.rst_p     (periph_rst),
		.op_i      (gpio_op),
		.addr_i    (gpio_addr),
		.data_i    (gpio_wdata),
		.sel_i     (gpio_sel),
		.gp_i      (gp_i),
		.data_o    (gpio_rdata),
		.rdy_o     (gpio_rdy),
		.gp_o      (gp_o)
	);

	// Board reset only reaches the sequencer.
	rst_sequencer rst_sequencer_inst (
		.clk100mhz    (clk100mhz),
		.rst_p        (rst_p),
		.sw_rst0_i    (sw_rst0),
		.sw_rst1_i    (sw_rst1),
		.periph_rst_o (periph_rst)
	);

	assign periph_rst_o = periph_rst;

endmodule

`default_nettype wire

//--- verification/tb_bus_tasks.svh
// ------------------------------------------------------------
// PI1 master tasks and the value check, included in the testbench module.
// ------------------------------------------------------------
`ifndef TB_BUS_TASKS_SVH
`define TB_BUS_TASKS_SVH

localparam int RDY_WAIT_LIMIT = 16;

task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
	assert (got === exp) else begin
		$display("mismatch at %0d ns: %s is %h, expected %h", $time, name, got, exp);
		mismatch_errors++;
	end
endtask

// One access. Ready is looked at on the falling edge, where it is stable.
task automatic run_access(input logic [1:0] op, input logic [soc_pkg::ADDRBITSZ-1:0] addr,
	input logic [31:0] wdata, input logic [3:0] sel, output logic [31:0] rdata,
	output int latency);
	latency = 0;
	m_op_i = op;
	m_addr_i = addr;
	m_data_i = wdata;
	m_sel_i = sel;
	@(negedge clk100mhz);
	while (!m_rdy_o && latency < RDY_WAIT_LIMIT) begin
		latency++;
		@(negedge clk100mhz);
	end
	if (!m_rdy_o) begin
		$display("error at %0d ns: no ready for the access to word %0d", $time, addr);
		other_errors++;
	end
	rdata = m_data_o;
	@(posedge clk100mhz); // Completing edge.
	#1;
	m_op_i = soc_pkg::PI1_OP_IDLE;
endtask

task automatic write_word(input logic [soc_pkg::ADDRBITSZ-1:0] addr, input logic [31:0] wdata,
	input logic [3:0] sel);
	logic [31:0] unused_data;
	int latency;
	run_access(soc_pkg::PI1_OP_WRITE, addr, wdata, sel, unused_data, latency);
endtask

task automatic read_word(input logic [soc_pkg::ADDRBITSZ-1:0] addr, output logic [31:0] rdata);
	int latency;
	run_access(soc_pkg::PI1_OP_READ, addr, 32'd0, 4'hf, rdata, latency);
endtask

`endif

//--- verification/tb_soc_top.sv
// ------------------------------------------------------------
// Testbench for soc_top. Drives the PI1 master port through reset,
// device table, GPIO, activity and software reset checks.
// ------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module tb_soc_top;

	// Whole run takes about 2000 cycles.
	localparam int TIMEOUT_CYCLES = 4000;
	localparam logic [soc_pkg::ADDRBITSZ-1:0] GPIO_IN_ADDR = soc_pkg::GPIO_BASE;
	localparam logic [soc_pkg::ADDRBITSZ-1:0] GPIO_OUT_ADDR = soc_pkg::GPIO_BASE + 30'd1;
	localparam logic [soc_pkg::ADDRBITSZ-1:0] CTRL_ADDR =
		soc_pkg::DEVTBL_BASE + 30'(soc_pkg::DEVTBL_CTRL_WORD);

	logic clk100mhz = 1'b0;
	logic rst_p;
	logic [1:0] m_op_i;
	logic [soc_pkg::ADDRBITSZ-1:0] m_addr_i;
	logic [soc_pkg::ARCHBITSZ-1:0] m_data_i;
	logic [soc_pkg::SELBITSZ-1:0] m_sel_i;
	logic [soc_pkg::GPIO_COUNT-1:0] gp_i;
	logic [soc_pkg::ARCHBITSZ-1:0] m_data_o;
	logic m_rdy_o;
	logic [soc_pkg::GPIO_COUNT-1:0] gp_o;
	logic periph_rst_o;
	logic activity_o;

	int mismatch_errors = 0;
	int other_errors = 0;
	int assert_errors = 0;
	int cycle_count = 0;
	int act_pulses = 0;
	logic checks_on = 1'b0;
	integer seed;

	always #5 clk100mhz = ~clk100mhz;

	soc_top soc_top_inst (
		.clk100mhz    (clk100mhz),
		.rst_p        (rst_p),
		.m_op_i       (m_op_i),
		.m_addr_i     (m_addr_i),
		.m_data_i     (m_data_i),
		.m_sel_i      (m_sel_i),
		.gp_i         (gp_i),
		.m_data_o     (m_data_o),
		.m_rdy_o      (m_rdy_o),
		.gp_o         (gp_o),
		.periph_rst_o (periph_rst_o),
		.activity_o   (activity_o)
	);

	`include "tb_bus_tasks.svh"

	task automatic idle_cycles(input int n);
		repeat (n) @(posedge clk100mhz);
		#1;
	endtask

	task automatic wait_reset_rise();
		int waited;
		waited = 0;
		while (!periph_rst_o && waited < 8) begin
			@(posedge clk100mhz);
			#1;
			waited++;
		end
		assert (periph_rst_o) else begin
			$display("error at %0d ns: periph_rst_o did not rise after the control write", $time);
			other_errors++;
		end
	endtask

	task automatic check_reset_release(input int min_cycles, input int max_cycles);
		int high_cycles;
		high_cycles = 0;
		while (periph_rst_o && high_cycles <= max_cycles) begin
			@(posedge clk100mhz);
			#1;
			high_cycles++;
		end
		assert (high_cycles >= min_cycles && high_cycles <= max_cycles) else begin
			$display("error at %0d ns: periph_rst_o held %0d cycles, allowed %0d to %0d",
				$time, high_cycles, min_cycles, max_cycles);
			other_errors++;
		end
	endtask

	// Id at word 2k, useintr flag and map size at word 2k+1.
	function automatic logic [31:0] expected_table_word(input int word);
		case (word)
			0: return soc_pkg::DEVTBL_ID;
			1: return {soc_pkg::USEINTR_FLAGS[0], 1'b0, soc_pkg::DEVTBL_MAPSZ};
			2: return soc_pkg::GPIO_ID;
			3: return {soc_pkg::USEINTR_FLAGS[1], 1'b0, soc_pkg::GPIO_MAPSZ};
			4: return soc_pkg::INVALID_ID;
			5: return {soc_pkg::USEINTR_FLAGS[2], 1'b0, soc_pkg::INVALID_MAPSZ};
			default: return 32'd0; // Control bits are clear here too.
		endcase
	endfunction

	task automatic report_counts();
		$display("errors: %0d mismatches, %0d assertion failures, %0d other failures",
			mismatch_errors, assert_errors, other_errors);
	endtask

	// ------------------------------------------------------------
	// Concurrent checks.
	assert property (@(posedge clk100mhz) disable iff (!checks_on || periph_rst_o)
		(m_op_i != soc_pkg::PI1_OP_IDLE && !m_rdy_o) |=> m_rdy_o)
	else begin
		$display("error at %0d ns: m_rdy_o not high one cycle after the request", $time);
		assert_errors++;
	end

	assert property (@(posedge clk100mhz) disable iff (!checks_on)
		(periph_rst_o && $past(periph_rst_o)) |-> (!m_rdy_o && !activity_o && gp_o == '0))
	else begin
		$display("error at %0d ns: outputs not idle under peripheral reset", $time);
		assert_errors++;
	end

	always @(negedge clk100mhz) begin
		if (activity_o) act_pulses++;
	end

	always @(posedge clk100mhz) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			report_counts();
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	// ------------------------------------------------------------
	// Stimulus.
	initial begin
		logic [31:0] rdata;
		logic [31:0] rnd;
		logic [7:0] held;
		int latency;
		int pulses_before;
		int low_cycles;

		seed = 32'hfe8b_28e9;
		rst_p = 1'b1;
		m_op_i = soc_pkg::PI1_OP_IDLE;
		m_addr_i = '0;
		m_data_i = '0;
		m_sel_i = '0;
		gp_i = '0;

		// Board reset for 8 cycles, then the counted release.
		repeat (2) @(posedge clk100mhz);
		#1;
		checks_on = 1'b1;
		idle_cycles(6);
		rst_p = 1'b0;
		check_reset_release(255, 258);
		check_value("gp_o", 32'(gp_o), 32'd0);
		check_value("activity_o", 32'(activity_o), 32'd0);

		for (int w = 0; w < 16; w++) begin
			read_word(soc_pkg::DEVTBL_BASE + 30'(w), rdata);
			check_value($sformatf("m_data_o table word %0d", w), rdata, expected_table_word(w));
		end
		run_access(soc_pkg::PI1_OP_READ, 30'd2000, 32'd0, 4'hf, rdata, latency);
		check_value("m_data_o invalid device", rdata, 32'd0);
		check_value("m_rdy_o latency", 32'(latency), 32'd1);

		// GPIO outputs, sel gating and the input synchroniser.
		for (int i = 0; i < 4; i++) begin
			rnd = $random(seed);
			write_word(GPIO_OUT_ADDR, rnd, 4'b0001);
			check_value("gp_o", 32'(gp_o), 32'(rnd[7:0]));
			read_word(GPIO_OUT_ADDR, rdata);
			check_value("m_data_o gpio out", rdata, 32'(rnd[7:0]));
		end
		held = gp_o;
		write_word(GPIO_OUT_ADDR, 32'(~held), 4'b1110);
		check_value("gp_o", 32'(gp_o), 32'(held));
		for (int i = 0; i < 4; i++) begin
			rnd = $random(seed);
			gp_i = rnd[7:0];
			idle_cycles(3);
			read_word(GPIO_IN_ADDR, rdata);
			check_value("m_data_o gpio in", rdata, 32'(rnd[7:0]));
		end
		read_word(GPIO_IN_ADDR + 30'd2, rdata);
		check_value("m_data_o gpio word 2", rdata, 32'd0);
		read_word(GPIO_IN_ADDR + 30'd3, rdata);
		check_value("m_data_o gpio word 3", rdata, 32'd0);

		// One blink, 127 cycles of hold-off, then a new blink.
		idle_cycles(140);
		pulses_before = act_pulses;
		read_word(soc_pkg::DEVTBL_BASE, rdata);
		// A read completes every 2 cycles, the last one on hold-off cycle 126.
		for (int i = 0; i < 63; i++) begin
			read_word(GPIO_IN_ADDR, rdata);
		end
		check_value("activity_o pulses", 32'(act_pulses - pulses_before), 32'd1);
		read_word(GPIO_IN_ADDR, rdata);
		idle_cycles(2);
		check_value("activity_o pulses", 32'(act_pulses - pulses_before), 32'd2);

		// Warm (2), then cold (3).
		for (int v = 2; v <= 3; v++) begin
			write_word(GPIO_OUT_ADDR, 32'h5a, 4'b0001);
			write_word(CTRL_ADDR, 32'(v), 4'b0001);
			wait_reset_rise();
			check_reset_release(255, 259);
			check_value("gp_o", 32'(gp_o), 32'd0);
			read_word(GPIO_OUT_ADDR, rdata);
			check_value("m_data_o gpio out", rdata, 32'd0);
			read_word(CTRL_ADDR, rdata);
			check_value("m_data_o control word", rdata, 32'd0);
		end

		// Power-off holds until the board reset.
		write_word(CTRL_ADDR, 32'd1, 4'b0001);
		wait_reset_rise();
		m_op_i = soc_pkg::PI1_OP_READ; // A request under reset must get no ready.
		m_addr_i = GPIO_IN_ADDR;
		low_cycles = 0;
		repeat (600) begin
			@(posedge clk100mhz);
			#1;
			if (!periph_rst_o) low_cycles++;
		end
		m_op_i = soc_pkg::PI1_OP_IDLE;
		assert (low_cycles == 0) else begin
			$display("error at %0d ns: periph_rst_o fell during power-off", $time);
			other_errors++;
		end
		rst_p = 1'b1;
		idle_cycles(2);
		rst_p = 1'b0;
		check_reset_release(255, 258);
		check_value("gp_o", 32'(gp_o), 32'd0);
		check_value("activity_o", 32'(activity_o), 32'd0);

		report_counts();
		if (mismatch_errors + other_errors + assert_errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- build.f
+incdir+verification
source/soc_pkg.sv
source/rst_sequencer.sv
source/devtbl_regs.sv
source/gpio_port.sv
source/pi1_router.sv
source/soc_top.sv
verification/tb_soc_top.sv

//--- Makefile
# Verilator build and run for the SoC bus fabric testbench.

VERILATOR  = verilator
TOP        = tb_soc_top
FILELIST   = build.f
SIM_FLAGS  = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing --assert
BUILD_DIR  = obj_dir
LOG        = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# The run counts as passed only if the log holds the pass line.
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
